//--- hdl/predecodePkg.sv
// Shared widths, types and class-bit positions for the fetch predecode pipeline.
// Every predecode module imports this package in its header.

package predecodePkg;

  // bundle layout
  localparam int NumParcels = 15;
  localparam int ParcelW = 16;
  localparam int BundleW = 256;
  localparam int EndFlagLo = NumParcels * ParcelW;
  localparam int SplitBit = BundleW - 1;

  // longest instruction kept in a slot
  localparam int InstrParcels = 4;

  typedef logic [ParcelW-1:0] parcelT;
  typedef logic [BundleW-1:0] bundleT;

  // first parcel sits in the low bits, unused parcels are zero
  typedef logic [InstrParcels*ParcelW-1:0] instrT;

  // length minus one
  typedef logic [1:0] lenT;

  typedef logic [3:0] offT;
  typedef logic [3:0] slotT;
  typedef logic [7:0] classT;
  typedef logic [4:0] regT;

  // class bit positions
  localparam int clsAlu = 0;
  localparam int clsShift = 1;
  localparam int clsMul = 2;
  localparam int clsLoad = 3;
  localparam int clsStore = 4;
  localparam int clsJump = 5;
  localparam int clsIndir = 6;
  localparam int clsSys = 7;

  // reported when no link instruction is present
  localparam regT NoLinkReg = regT'(31);

endpackage

//--- hdl/instrClassifier.sv
// Combinational opcode decode for one instruction.
// Gives the class bits and whether the instruction is a link, with its register.
// len of zero selects the short (one parcel) table.

`timescale 1ns/1ps

module instrClassifier
  import predecodePkg::*;
(
  input  instrT instr,
  input  lenT   len,
  output classT cls,
  output logic  isLnk,
  output regT   lnkReg
);

  parcelT      first;
  parcelT      second;
  logic [7:0]  opc;
  logic [5:0]  sub;
  logic [2:0]  kind;
  logic        isLong;

  // long forms
  logic isAluMul;
  logic isShift;
  logic isLdSt;
  logic isCondJump;
  logic isUncond;
  logic isIndirJump;
  logic isCall;
  logic isRet;
  logic isCallPrep;
  logic isSys;

  // short forms
  logic subIsAlu;
  logic subIsShift;
  logic subIsCondJump;

  assign first = instr[ParcelW-1:0];
  assign second = instr[2*ParcelW-1:ParcelW];
  assign opc = first[7:0];
  assign sub = first[5:0];
  assign kind = first[15:13];
  assign isLong = len != 2'd0;

  assign isAluMul = isLong && opc <= 8'd39;
  assign isShift = isLong && opc >= 8'd40 && opc <= 8'd45;
  assign isLdSt = isLong && opc >= 8'd64 && opc <= 8'd159;
  assign isCondJump = isLong && opc[7:4] == 4'b1010;
  assign isUncond = isLong && opc == 8'd181;
  assign isIndirJump = isLong && opc == 8'd182 && kind == 3'd0;
  assign isCall = isLong && opc == 8'd182 && (kind == 3'd1 || kind == 3'd2);
  assign isRet = isLong && opc == 8'd182 && kind == 3'd3;
  assign isCallPrep = isLong && opc == 8'd199;
  assign isSys = isLong && opc == 8'hff;

  assign subIsAlu = !isLong && sub <= 6'd19;
  assign subIsShift = !isLong && sub >= 6'd21 && sub <= 6'd31 && sub[0];
  // zero offset is a hint
  assign subIsCondJump = !isLong && sub[5:2] == 4'b1100 && first[15:8] != 8'd0;

  always_comb begin
    cls = '0;
    cls[clsAlu] = (isAluMul && !opc[2]) || isCondJump || subIsAlu || subIsCondJump;
    cls[clsMul] = isAluMul && opc[2];
    cls[clsShift] = isShift || subIsShift;
    cls[clsLoad] = isLdSt && !opc[0];
    cls[clsStore] = (isLdSt && opc[0]) || isCall;
    cls[clsJump] = isCondJump || isUncond || isIndirJump || isCall || isRet || subIsCondJump;
    cls[clsIndir] = isIndirJump || isRet;
    cls[clsSys] = isSys;
  end

  assign isLnk = isRet || isCallPrep;

  // call-prep names its register in bits 20 to 16
  assign lnkReg = isCallPrep ? second[4:0] : NoLinkReg;

endmodule

//--- hdl/boundaryStage.sv
// First predecode stage. Walks the end-of-instruction flags from startOff,
// packs each instruction into an output slot and registers the result.
// Over-long instructions keep their first four parcels and raise error.

`timescale 1ns/1ps

module boundaryStage
  import predecodePkg::*;
#(
  parameter int MaxInstr = 12
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                inValid,
  output logic                inReady,
  input  bundleT              bundle,
  input  offT                 startOff,
  output logic                bValid,
  input  logic                bReady,
  output instrT               sInstr [MaxInstr],
  output lenT                 sLen [MaxInstr],
  output offT                 sOff [MaxInstr],
  output logic [MaxInstr-1:0] sEn,
  output logic                error,
  output logic                split
);

  logic [NumParcels-1:0] endFlag;
  logic                  accept;

  instrT               nxtInstr [MaxInstr];
  lenT                 nxtLen [MaxInstr];
  offT                 nxtOff [MaxInstr];
  logic [MaxInstr-1:0] nxtEn;
  logic                overLong;
  logic                nxtError;
  int                  nInstr;
  int                  runLen;
  parcelT              parcel;

  // last parcel always closes an instruction
  assign endFlag = {1'b1, bundle[EndFlagLo +: NumParcels-1]};

  always_comb begin
    nxtInstr = '{default: '0};
    nxtLen = '{default: '0};
    nxtOff = '{default: '0};
    nxtEn = '0;
    overLong = 1'b0;
    nInstr = 0;
    runLen = 0;
    parcel = '0;
    for (int p = 0; p < NumParcels; p++) begin
      if (p >= startOff) begin
        parcel = bundle[p*ParcelW +: ParcelW];
        if (nInstr < MaxInstr) begin
          if (runLen == 0) begin
            nxtEn[nInstr] = 1'b1;
            nxtOff[nInstr] = offT'(p);
          end
          if (runLen < InstrParcels) begin
            nxtInstr[nInstr][runLen*ParcelW +: ParcelW] = parcel;
            nxtLen[nInstr] = lenT'(runLen);
          end
        end
        // fifth parcel or later of one instruction
        if (runLen >= InstrParcels) begin
          overLong = 1'b1;
        end
        if (endFlag[p]) begin
          nInstr = nInstr + 1;
          runLen = 0;
        end else begin
          runLen = runLen + 1;
        end
      end
    end
    nxtError = overLong || (nInstr > MaxInstr);
  end

  assign inReady = !bValid || bReady;
  assign accept = inValid && inReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      bValid <= 1'b0;
    end else if (inReady) begin
      bValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      sInstr <= nxtInstr;
      sLen <= nxtLen;
      sOff <= nxtOff;
      sEn <= nxtEn;
      error <= nxtError;
      split <= bundle[SplitBit];
    end
  end

endmodule

//--- hdl/classifyStage.sv
// Second predecode stage. One classifier per slot, results registered
// together with the slot fields from the boundary stage.

`timescale 1ns/1ps

module classifyStage
  import predecodePkg::*;
#(
  parameter int MaxInstr = 12
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                bValid,
  output logic                bReady,
  input  instrT               sInstr [MaxInstr],
  input  lenT                 sLen [MaxInstr],
  input  offT                 sOff [MaxInstr],
  input  logic [MaxInstr-1:0] sEn,
  input  logic                error,
  input  logic                split,
  output logic                cValid,
  input  logic                cReady,
  output instrT               cInstr [MaxInstr],
  output lenT                 cLen [MaxInstr],
  output offT                 cOff [MaxInstr],
  output logic [MaxInstr-1:0] cEn,
  output logic                cError,
  output logic                cSplit,
  output classT               sCls [MaxInstr],
  output logic [MaxInstr-1:0] sIsLnk,
  output regT                 sLnkReg [MaxInstr]
);

  classT               rawCls [MaxInstr];
  logic [MaxInstr-1:0] rawLnk;
  regT                 rawReg [MaxInstr];
  logic                accept;

  for (genvar s = 0; s < MaxInstr; s++) begin : gSlot
    instrClassifier uCls (
      .instr (sInstr[s]),
      .len   (sLen[s]),
      .cls   (rawCls[s]),
      .isLnk (rawLnk[s]),
      .lnkReg(rawReg[s])
    );
  end

  assign bReady = !cValid || cReady;
  assign accept = bValid && bReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      cValid <= 1'b0;
    end else if (bReady) begin
      cValid <= bValid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cInstr <= sInstr;
      cLen <= sLen;
      cOff <= sOff;
      cEn <= sEn;
      cError <= error;
      cSplit <= split;
      // empty slots carry no class and no link
      for (int s = 0; s < MaxInstr; s++) begin
        sCls[s] <= sEn[s] ? rawCls[s] : '0;
        sIsLnk[s] <= sEn[s] && rawLnk[s];
        sLnkReg[s] <= sEn[s] ? rawReg[s] : '0;
      end
    end
  end

endmodule

//--- hdl/jumpLinkStage.sv
// Third predecode stage. Collects the slots of the first MaxJumps jumps
// and the first link instruction, then registers all result ports.

`timescale 1ns/1ps

module jumpLinkStage
  import predecodePkg::*;
#(
  parameter int MaxInstr = 12,
  parameter int MaxJumps = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                cValid,
  output logic                cReady,
  input  instrT               cInstr [MaxInstr],
  input  lenT                 cLen [MaxInstr],
  input  offT                 cOff [MaxInstr],
  input  logic [MaxInstr-1:0] cEn,
  input  logic                cError,
  input  logic                cSplit,
  input  classT               sCls [MaxInstr],
  input  logic [MaxInstr-1:0] sIsLnk,
  input  regT                 sLnkReg [MaxInstr],
  output logic                outValid,
  input  logic                outReady,
  output logic [MaxInstr-1:0] instrEn,
  output instrT               instr [MaxInstr],
  output lenT                 len [MaxInstr],
  output offT                 off [MaxInstr],
  output classT               cls [MaxInstr],
  output logic                split,
  output logic                error,
  output logic [MaxJumps-1:0] jumpEn,
  output slotT                jumpSlot [MaxJumps],
  output logic                jumpError,
  output logic                lnkEn,
  output regT                 lnkReg,
  output slotT                lnkSlot
);

  logic [MaxJumps-1:0] nxtJumpEn;
  slotT                nxtJumpSlot [MaxJumps];
  logic                nxtJumpError;
  logic                nxtLnkEn;
  regT                 nxtLnkReg;
  slotT                nxtLnkSlot;
  int                  nJump;
  logic                accept;

  // slot fields arrive masked, so a disabled slot never matches
  always_comb begin
    nxtJumpEn = '0;
    nxtJumpSlot = '{default: '0};
    nxtLnkEn = 1'b0;
    nxtLnkReg = NoLinkReg;
    nxtLnkSlot = '0;
    nJump = 0;
    for (int s = 0; s < MaxInstr; s++) begin
      if (sCls[s][clsJump]) begin
        if (nJump < MaxJumps) begin
          nxtJumpEn[nJump] = 1'b1;
          nxtJumpSlot[nJump] = slotT'(s);
        end
        nJump = nJump + 1;
      end
      if (sIsLnk[s] && !nxtLnkEn) begin
        nxtLnkEn = 1'b1;
        nxtLnkReg = sLnkReg[s];
        nxtLnkSlot = slotT'(s);
      end
    end
    nxtJumpError = nJump > MaxJumps;
  end

  assign cReady = !outValid || outReady;
  assign accept = cValid && cReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (cReady) begin
      outValid <= cValid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      instrEn <= cEn;
      instr <= cInstr;
      len <= cLen;
      off <= cOff;
      cls <= sCls;
      split <= cSplit;
      error <= cError;
      jumpEn <= nxtJumpEn;
      jumpSlot <= nxtJumpSlot;
      jumpError <= nxtJumpError;
      lnkEn <= nxtLnkEn;
      lnkReg <= nxtLnkReg;
      lnkSlot <= nxtLnkSlot;
    end
  end

endmodule

//--- hdl/predecoder.sv
// Predecode front of the fetch path, three stages with valid/ready between them.
// boundary split, then per-slot classification, then jump and link gathering.

`timescale 1ns/1ps

module predecoder
  import predecodePkg::*;
#(
  parameter int MaxInstr = 12,
  parameter int MaxJumps = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                inValid,
  output logic                inReady,
  input  bundleT              bundle,
  input  offT                 startOff,
  output logic                outValid,
  input  logic                outReady,
  output logic [MaxInstr-1:0] instrEn,
  output instrT               instr [MaxInstr],
  output lenT                 len [MaxInstr],
  output offT                 off [MaxInstr],
  output classT               cls [MaxInstr],
  output logic                split,
  output logic                error,
  output logic [MaxJumps-1:0] jumpEn,
  output slotT                jumpSlot [MaxJumps],
  output logic                jumpError,
  output logic                lnkEn,
  output regT                 lnkReg,
  output slotT                lnkSlot
);

  // boundary to classify
  logic                bValid;
  logic                bReady;
  instrT               sInstr [MaxInstr];
  lenT                 sLen [MaxInstr];
  offT                 sOff [MaxInstr];
  logic [MaxInstr-1:0] sEn;
  logic                sError;
  logic                sSplit;

  // classify to jump/link
  logic                cValid;
  logic                cReady;
  instrT               cInstr [MaxInstr];
  lenT                 cLen [MaxInstr];
  offT                 cOff [MaxInstr];
  logic [MaxInstr-1:0] cEn;
  logic                cError;
  logic                cSplit;
  classT               sCls [MaxInstr];
  logic [MaxInstr-1:0] sIsLnk;
  regT                 sLnkReg [MaxInstr];

  boundaryStage #(.MaxInstr(MaxInstr)) uBoundary (
    .clk, .rst, .inValid, .inReady, .bundle, .startOff,
    .bValid, .bReady, .sInstr, .sLen, .sOff, .sEn,
    .error(sError), .split(sSplit)
  );

  classifyStage #(.MaxInstr(MaxInstr)) uClassify (
    .clk, .rst, .bValid, .bReady, .sInstr, .sLen, .sOff, .sEn,
    .error(sError), .split(sSplit),
    .cValid, .cReady, .cInstr, .cLen, .cOff, .cEn, .cError, .cSplit,
    .sCls, .sIsLnk, .sLnkReg
  );

  jumpLinkStage #(.MaxInstr(MaxInstr), .MaxJumps(MaxJumps)) uJumpLink (
    .clk, .rst, .cValid, .cReady, .cInstr, .cLen, .cOff, .cEn, .cError, .cSplit,
    .sCls, .sIsLnk, .sLnkReg, .outValid, .outReady,
    .instrEn, .instr, .len, .off, .cls, .split, .error,
    .jumpEn, .jumpSlot, .jumpError, .lnkEn, .lnkReg, .lnkSlot
  );

endmodule

//--- bench/clockGen.sv
// Testbench clock and reset, 100 ns period with rst held for the first cycles.

`timescale 1ns/1ps

module clockGen #(
  parameter int HalfPeriod = 50,
  parameter int ResetCycles = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- bench/predecoder_props.sv
// Output handshake properties of the predecoder, bound into every instance.
// nFail counts failed assertions and is read by the testbench at the end.

`timescale 1ns/1ps

module predecoderProps
  import predecodePkg::*;
#(
  parameter int MaxInstr = 12,
  parameter int MaxJumps = 4
) (
  input logic                clk,
  input logic                rst,
  input logic                outValid,
  input logic                outReady,
  input logic [MaxInstr-1:0] instrEn,
  input logic [MaxJumps-1:0] jumpEn,
  input logic                jumpError,
  input logic                lnkEn,
  input regT                 lnkReg,
  input slotT                lnkSlot,
  input logic                error,
  input logic                split
);

  int nFail = 0;

  assert property (@(posedge clk) rst |=> !outValid)
    else begin
      $error("outValid high in the cycle after reset");
      nFail++;
    end

  // a stalled result must hold until it is taken
  assert property (@(posedge clk) disable iff (rst)
    outValid && !outReady |=> outValid
      && $stable({instrEn, jumpEn, jumpError, lnkEn, lnkReg, lnkSlot, error, split}))
    else begin
      $error("result changed while stalled");
      nFail++;
    end

  // filled jump entries start at bit 0 with no gap
  assert property (@(posedge clk) disable iff (rst)
    outValid |-> ((jumpEn & (jumpEn + 1'b1)) == '0))
    else begin
      $error("jumpEn has a gap");
      nFail++;
    end

endmodule

bind predecoder predecoderProps #(.MaxInstr(MaxInstr), .MaxJumps(MaxJumps)) props0 (
  .clk, .rst, .outValid, .outReady, .instrEn, .jumpEn, .jumpError,
  .lnkEn, .lnkReg, .lnkSlot, .error, .split
);

//--- bench/predecoderTb.sv
// Testbench for the predecoder. Random bundles from a fixed seed are fed in,
// a reference model predicts each result and queues it, and every output
// transfer is compared slot by slot against the head of that queue.

`timescale 1ns/1ps

module predecoderTb;
  import predecodePkg::*;

  localparam int MaxInstr = 12;
  localparam int MaxJumps = 4;
  localparam int NumBundles = 240;
  localparam int TimeoutCycles = 4 * NumBundles + 100;

  typedef struct packed {
    logic [MaxInstr-1:0]  en;
    instrT [MaxInstr-1:0] instr;
    lenT [MaxInstr-1:0]   len;
    offT [MaxInstr-1:0]   off;
    classT [MaxInstr-1:0] cls;
    logic                 split;
    logic                 error;
    logic [MaxJumps-1:0]  jEn;
    slotT [MaxJumps-1:0]  jSlot;
    logic                 jErr;
    logic                 lnkEn;
    regT                  lnkReg;
    slotT                 lnkSlot;
  } expectT;

  logic                clk;
  logic                rst;
  logic                inValid;
  logic                inReady;
  logic                outValid;
  logic                outReady;
  bundleT              bundle;
  offT                 startOff;
  logic [MaxInstr-1:0] instrEn;
  instrT               instr [MaxInstr];
  lenT                 len [MaxInstr];
  offT                 off [MaxInstr];
  classT               cls [MaxInstr];
  logic                split;
  logic                error;
  logic [MaxJumps-1:0] jumpEn;
  slotT                jumpSlot [MaxJumps];
  logic                jumpError;
  logic                lnkEn;
  regT                 lnkReg;
  slotT                lnkSlot;

  int     seed;
  int     cycle;
  int     lastLow;
  int     nBuilt;
  int     accCycle;
  int     failTotal;
  int     checkTotal;
  int     mode;
  bit     haveBundle;
  expectT expQ [$];
  int     acceptQ [$];
  int     nChecks [6];
  int     nErrors [6];
  string  behName [6] = '{"boundaries", "classes", "jumps", "link", "errors", "backpressure"};

  // low bytes drawn for first parcels, long and short
  logic [7:0] longOps [16] = '{8'd3, 8'd4, 8'd39, 8'd42, 8'd45, 8'd64, 8'd159, 8'd170,
                              8'd181, 8'd182, 8'd182, 8'd182, 8'd199, 8'd255, 8'd50, 8'd230};
  logic [5:0] shortOps [10] = '{6'd0, 6'd19, 6'd20, 6'd21, 6'd31, 6'd22, 6'd48, 6'd51,
                                6'd52, 6'd63};

  clockGen clk0 (.clk, .rst);

  predecoder #(.MaxInstr(MaxInstr), .MaxJumps(MaxJumps)) dut0 (
    .clk, .rst, .inValid, .inReady, .bundle, .startOff, .outValid, .outReady,
    .instrEn, .instr, .len, .off, .cls, .split, .error,
    .jumpEn, .jumpSlot, .jumpError, .lnkEn, .lnkReg, .lnkSlot
  );

  function automatic parcelT firstParcel(input bit isShort);
    logic [7:0] hi;
    hi = 8'($random(seed));
    if (isShort) begin
      // zero high byte makes a short jump a hint
      if ({$random(seed)} % 4 == 0) begin
        hi = 8'd0;
      end
      return {hi, 2'b00, shortOps[{$random(seed)} % 10]};
    end
    return {hi, longOps[{$random(seed)} % 16]};
  endfunction

  function automatic bundleT makeBundle(input int kind);
    bundleT b;
    int     p;
    int     run;
    b = '0;
    b[SplitBit] = 1'($random(seed));
    p = 0;
    while (p < NumParcels) begin
      // kind 6 packs short instructions, kind 5 allows over-long ones
      run = (kind == 6) ? 1 : 1 + {$random(seed)} % ((kind == 5) ? 7 : 4);
      for (int q = 0; q < run && p < NumParcels; q++) begin
        b[p*ParcelW +: ParcelW] = (q == 0) ? firstParcel(run == 1) : parcelT'($random(seed));
        // kind 7 turns long instructions into jumps, often more than four
        if (kind == 7 && q == 0 && run > 1) begin
          b[p*ParcelW +: 8] = 8'd181;
        end
        b[EndFlagLo + p] = (q == run - 1);
        p++;
      end
    end
    return b;
  endfunction

  function automatic classT classOf(input parcelT p0, input bit isShort);
    classT      c;
    logic [7:0] op;
    c = '0;
    op = p0[7:0];
    if (isShort) begin
      if (p0[5:0] <= 6'd19) begin
        c[clsAlu] = 1'b1;
      end else if (p0[5:0] >= 6'd21 && p0[5:0] <= 6'd31 && p0[0]) begin
        c[clsShift] = 1'b1;
      end else if (p0[5:0] >= 6'd48 && p0[5:0] <= 6'd51 && p0[15:8] != 8'd0) begin
        c[clsJump] = 1'b1;
        c[clsAlu] = 1'b1;
      end
    end else if (op <= 8'd39) begin
      c[op[2] ? clsMul : clsAlu] = 1'b1;
    end else if (op <= 8'd45) begin
      c[clsShift] = 1'b1;
    end else if (op >= 8'd64 && op <= 8'd159) begin
      c[op[0] ? clsStore : clsLoad] = 1'b1;
    end else if (op >= 8'd160 && op <= 8'd175) begin
      c[clsJump] = 1'b1;
      c[clsAlu] = 1'b1;
    end else if (op == 8'd181) begin
      c[clsJump] = 1'b1;
    end else if (op == 8'd182) begin
      c[clsJump] = p0[15:13] <= 3'd3;
      c[clsIndir] = p0[15:13] == 3'd0 || p0[15:13] == 3'd3;
      c[clsStore] = p0[15:13] == 3'd1 || p0[15:13] == 3'd2;
    end else if (op == 8'd255) begin
      c[clsSys] = 1'b1;
    end
    return c;
  endfunction

  function automatic expectT predict(input bundleT b, input offT so);
    expectT e;
    int     n;
    int     start;
    int     run;
    int     nJump;
    parcelT p0;
    logic   isRet;
    e = '0;
    e.split = b[SplitBit];
    e.lnkReg = NoLinkReg;
    n = 0;
    nJump = 0;
    start = int'(so);
    for (int p = int'(so); p < NumParcels; p++) begin
      if (p == NumParcels - 1 || b[EndFlagLo + p]) begin
        run = p - start + 1;
        e.error |= run > 4;
        if (n < MaxInstr) begin
          e.en[n] = 1'b1;
          e.off[n] = offT'(start);
          e.len[n] = lenT'((run > 4 ? 4 : run) - 1);
          for (int q = 0; q < 4 && q < run; q++) begin
            e.instr[n][q*ParcelW +: ParcelW] = b[(start+q)*ParcelW +: ParcelW];
          end
          p0 = e.instr[n][15:0];
          e.cls[n] = classOf(p0, run == 1);
          if (e.cls[n][clsJump]) begin
            if (nJump < MaxJumps) begin
              e.jEn[nJump] = 1'b1;
              e.jSlot[nJump] = slotT'(n);
            end
            nJump++;
          end
          isRet = p0[7:0] == 8'd182 && p0[15:13] == 3'd3;
          if (!e.lnkEn && run > 1 && (isRet || p0[7:0] == 8'd199)) begin
            e.lnkEn = 1'b1;
            e.lnkReg = isRet ? regT'(31) : regT'(e.instr[n][20:16]);
            e.lnkSlot = slotT'(n);
          end
        end
        n++;
        start = p + 1;
      end
    end
    e.error |= n > MaxInstr;
    e.jErr = nJump > MaxJumps;
    return e;
  endfunction

  task automatic tally(input bit ok, input int beh, input string name,
                       input logic [63:0] got, input logic [63:0] exp);
    nChecks[beh]++;
    if (!ok) begin
      nErrors[beh]++;
      $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic checkClass(input string name, input classT got, input classT exp, input int beh);
    tally(got === exp, beh, name, 64'(got), 64'(exp));
  endtask

  task automatic checkInstr(input string name, input instrT got, input instrT exp, input int beh);
    tally(got === exp, beh, name, got, exp);
  endtask

  task automatic checkLen(input string name, input lenT got, input lenT exp, input int beh);
    tally(got === exp, beh, name, 64'(got), 64'(exp));
  endtask

  task automatic checkOff(input string name, input offT got, input offT exp, input int beh);
    tally(got === exp, beh, name, 64'(got), 64'(exp));
  endtask

  task automatic checkSlot(input string name, input slotT got, input slotT exp, input int beh);
    tally(got === exp, beh, name, 64'(got), 64'(exp));
  endtask

  task automatic checkReg(input string name, input regT got, input regT exp, input int beh);
    tally(got === exp, beh, name, 64'(got), 64'(exp));
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp, input int beh);
    tally(got === exp, beh, name, 64'(got), 64'(exp));
  endtask

  task automatic compareResult(input expectT e);
    for (int s = 0; s < MaxInstr; s++) begin
      checkFlag($sformatf("instrEn[%0d]", s), instrEn[s], e.en[s], 0);
      checkInstr($sformatf("instr[%0d]", s), instr[s], e.instr[s], 0);
      checkLen($sformatf("len[%0d]", s), len[s], e.len[s], 0);
      checkOff($sformatf("off[%0d]", s), off[s], e.off[s], 0);
      checkClass($sformatf("cls[%0d]", s), cls[s], e.cls[s], 1);
    end
    for (int j = 0; j < MaxJumps; j++) begin
      checkFlag($sformatf("jumpEn[%0d]", j), jumpEn[j], e.jEn[j], 2);
      checkSlot($sformatf("jumpSlot[%0d]", j), jumpSlot[j], e.jSlot[j], 2);
    end
    checkFlag("jumpError", jumpError, e.jErr, 2);
    checkFlag("lnkEn", lnkEn, e.lnkEn, 3);
    checkReg("lnkReg", lnkReg, e.lnkReg, 3);
    checkSlot("lnkSlot", lnkSlot, e.lnkSlot, 3);
    checkFlag("error", error, e.error, 4);
    checkFlag("split", split, e.split, 4);
  endtask

  initial begin
    seed = 16;
    inValid = 1'b0;
    bundle = '0;
    startOff = '0;
    outReady = 1'b0;
    cycle = 0;
    lastLow = -1;
    nBuilt = 0;
    haveBundle = 1'b0;
    @(negedge clk);
    while (rst) @(negedge clk);
    #1;
    checkFlag("inReady", inReady, 1'b1, 5);
    checkFlag("outValid", outValid, 1'b0, 5);
    while ((nBuilt < NumBundles || haveBundle || expQ.size() > 0) && cycle < TimeoutCycles) begin
      @(negedge clk);
      cycle++;
      if (!haveBundle && nBuilt < NumBundles && {$random(seed)} % 8 != 0) begin
        mode = nBuilt % 8;
        bundle = makeBundle(mode);
        startOff = (mode == 6) ? offT'({$random(seed)} % 2) : offT'({$random(seed)} % 15);
        haveBundle = 1'b1;
        nBuilt++;
      end
      inValid = haveBundle;
      // second half runs with outReady held high
      outReady = (nBuilt >= NumBundles / 2) || ({$random(seed)} % 4 != 0);
      #1;
      if (inValid && inReady) begin
        expQ.push_back(predict(bundle, startOff));
        acceptQ.push_back(cycle);
        haveBundle = 1'b0;
      end
      if (outValid && outReady) begin
        if (expQ.size() == 0) begin
          nErrors[5]++;
          $display("a result came out at t=%0t with no accepted bundle behind it", $time);
        end else begin
          compareResult(expQ.pop_front());
          accCycle = acceptQ.pop_front();
          if (lastLow < accCycle) begin
            tally(cycle - accCycle == 3, 5, "latency", 64'(cycle - accCycle), 64'd3);
          end
        end
      end
      if (!outReady) begin
        lastLow = cycle;
      end
    end
    if (cycle >= TimeoutCycles) begin
      nErrors[5]++;
      $display("timeout after %0d cycles, %0d results never came out", cycle, expQ.size());
    end else begin
      repeat (5) begin
        @(negedge clk);
        #1;
        if (outValid) begin
          nErrors[5]++;
          $display("an extra result appeared at t=%0t after all bundles were matched", $time);
        end
      end
    end
    failTotal = dut0.props0.nFail;
    if (failTotal != 0) begin
      $display("%0d assertion failures in the bound properties", failTotal);
    end
    checkTotal = 0;
    for (int b = 0; b < 6; b++) begin
      $display("%-12s %0d checks, %0d errors", behName[b], nChecks[b], nErrors[b]);
      checkTotal += nChecks[b];
      failTotal += nErrors[b];
    end
    $display("bundles %0d, checks %0d, failures %0d", nBuilt, checkTotal, failTotal);
    if (failTotal == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/predecodePkg.sv
hdl/instrClassifier.sv
hdl/boundaryStage.sv
hdl/classifyStage.sv
hdl/jumpLinkStage.sv
hdl/predecoder.sv
bench/clockGen.sv
bench/predecoder_props.sv
bench/predecoderTb.sv
